/* all.f */
+incdir+common
common/pi_bus_pkg.sv
spi/spi_byte.sv
logic/pi_com.sv
logic/bus_ram.sv
logic/pi_bridge_top.sv
verification/pi_bridge_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the bridge testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module pi_bridge_tb -Mdir obj_dir \
    && ./obj_dir/Vpi_bridge_tb > sim.log 2>&1 \
    || { echo "build or run did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TEST PASSED" sim.log \
    && echo "simulation ok" \
    || { echo "simulation reported a failure"; exit 1; }

/* verification/pi_bridge_tb.sv */
`timescale 1ns/1ps

`include "pi_bus_consts.svh"

module pi_bridge_tb;

    import pi_bus_pkg::*;

    localparam int MAX_ENTRIES      = 16;
    localparam int CYCLES_PER_ENTRY = 400;
    localparam int DONE_WAIT_LIMIT  = 200;
    localparam int REF_DEPTH        = 1 << (`PI_RAM_LO_BITS + 1);

    logic sys_clk;
    logic reset;
    logic spi_sclk;
    logic spi_mosi;
    logic pending_in;
    logic spi_miso;
    logic done_out;

    // stimulus table.
    string                 test_name  [MAX_ENTRIES];
    pi_cmd_len_e           test_cmd   [MAX_ENTRIES];
    logic [`PI_ADDR_W-1:0] test_addr  [MAX_ENTRIES];
    logic [`PI_DATA_W-1:0] test_data  [MAX_ENTRIES];
    bit                    test_abort [MAX_ENTRIES];
    int                    n_entries;

    // reference memory and address tracking.
    logic [`PI_DATA_W-1:0] ref_mem [REF_DEPTH];
    logic [`PI_ADDR_W-1:0] cur_addr;
    logic [31:0]           rand_state;

    int error_count;
    int check_count;
    int cycle_count;
    int cycle_limit;

    pi_bridge_top uut (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .spi_sclk   (spi_sclk),
        .spi_mosi   (spi_mosi),
        .pending_in (pending_in),
        .spi_miso   (spi_miso),
        .done_out   (done_out)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    // run limit scales with the table length.
    always @(posedge sys_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run went past %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // a16 plus the low bits select the byte.
    function automatic logic [`PI_RAM_LO_BITS:0] ram_index(input logic [`PI_ADDR_W-1:0] a);
        return {a[`PI_ADDR_W-1], a[`PI_RAM_LO_BITS-1:0]};
    endfunction

    task automatic add_entry(input string name, input pi_cmd_len_e cmd,
                             input logic [`PI_ADDR_W-1:0] addr,
                             input logic [`PI_DATA_W-1:0] data, input bit abort);
        test_name[n_entries]  = name;
        test_cmd[n_entries]   = cmd;
        test_addr[n_entries]  = addr;
        test_data[n_entries]  = data;
        test_abort[n_entries] = abort;
        n_entries++;
    endtask

    task automatic check_byte(input string name, input logic [`PI_DATA_W-1:0] expected,
                              input logic [`PI_DATA_W-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("Error: %s expected 0x%02h actual 0x%02h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            $display("Error: %s expected %b actual %b", name, expected, actual);
            error_count++;
        end
    endtask

    // spi mode 0, msb first, four sys_clk cycles per half period.
    task automatic shift_byte(input logic [`PI_DATA_W-1:0] tx,
                              output logic [`PI_DATA_W-1:0] rx);
        for (int i = `PI_DATA_W - 1; i >= 0; i--) begin
            spi_mosi = tx[i];
            spi_sclk = 1'b0;
            repeat (4) @(negedge sys_clk);
            rx[i]    = spi_miso;
            spi_sclk = 1'b1;
            repeat (4) @(negedge sys_clk);
        end
        spi_sclk = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one table entry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_entry(input int k);
        logic [`PI_DATA_W-1:0] cmd_byte;
        logic [`PI_DATA_W-1:0] wr_byte;
        logic [`PI_DATA_W-1:0] expect_byte;
        logic [`PI_DATA_W-1:0] rx;
        int                    wait_cycles;
        int                    errors_before;
        errors_before = error_count;
        wr_byte       = test_data[k];
        if (test_cmd[k] == CMD_WRITE_AT && test_data[k] == '0) begin
            rand_state = xorshift32(rand_state);
            wr_byte    = rand_state[`PI_DATA_W-1:0];
        end
        cmd_byte = '0;
        cmd_byte[`PI_CMD_LEN_HI:`PI_CMD_LEN_LO] = test_cmd[k];
        cmd_byte[`PI_CMD_A16_BIT]               = test_addr[k][`PI_ADDR_W-1];

        // predict the address and memory contents.
        case (test_cmd[k])
            CMD_READ_NEXT: cur_addr = cur_addr + 17'd1;
            CMD_READ_AT:   cur_addr = test_addr[k];
            default: begin
                if (test_abort[k]) begin
                    cur_addr[`PI_ADDR_W-1] = test_addr[k][`PI_ADDR_W-1];
                end else begin
                    cur_addr                    = test_addr[k];
                    ref_mem[ram_index(cur_addr)] = wr_byte;
                end
            end
        endcase
        expect_byte = ref_mem[ram_index(cur_addr)];

        pending_in = 1'b1;
        repeat (2) @(negedge sys_clk);
        shift_byte(cmd_byte, rx);
        if (test_cmd[k] == CMD_WRITE_AT) begin
            shift_byte(wr_byte, rx);
        end
        if (!test_abort[k]) begin
            if (test_cmd[k] != CMD_READ_NEXT) begin
                shift_byte(test_addr[k][15:8], rx);
                shift_byte(test_addr[k][7:0], rx);
            end
            wait_cycles = 0;
            while (!done_out && wait_cycles < DONE_WAIT_LIMIT) begin
                @(negedge sys_clk);
                wait_cycles++;
            end
            if (!done_out) begin
                $display("%s: done_out did not rise within %0d cycles",
                         test_name[k], DONE_WAIT_LIMIT);
                error_count++;
            end
            shift_byte(8'h00, rx);
            if (test_cmd[k] != CMD_WRITE_AT) begin
                check_byte(test_name[k], expect_byte, rx);
            end
        end
        pending_in = 1'b0;
        repeat (3) @(negedge sys_clk);
        check_level({test_name[k], " done_out"}, 1'b0, done_out);

        if (error_count == errors_before) begin
            $display("test %s ok", test_name[k]);
        end else begin
            $display("test %s mismatch", test_name[k]);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        reset       = 1'b1;
        spi_sclk    = 1'b0;
        spi_mosi    = 1'b0;
        pending_in  = 1'b0;
        rand_state  = 32'd77756;
        cur_addr    = '0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        n_entries   = 0;

        // zero data on a write means a random byte.
        // the aborted write targets the address still held from the read-next.
        add_entry("wr_00ff",     CMD_WRITE_AT,  17'h000ff, 8'h3c, 1'b0);
        add_entry("wr_0100",     CMD_WRITE_AT,  17'h00100, 8'h00, 1'b0);
        add_entry("rd_00ff",     CMD_READ_AT,   17'h000ff, 8'h00, 1'b0);
        add_entry("rn_carry",    CMD_READ_NEXT, 17'h00000, 8'h00, 1'b0);
        add_entry("wr_lo_a16",   CMD_WRITE_AT,  17'h00042, 8'h11, 1'b0);
        add_entry("wr_hi_a16",   CMD_WRITE_AT,  17'h10042, 8'h00, 1'b0);
        add_entry("wr_hi_043",   CMD_WRITE_AT,  17'h10043, 8'h5a, 1'b0);
        add_entry("rd_lo_a16",   CMD_READ_AT,   17'h00042, 8'h00, 1'b0);
        add_entry("rd_hi_a16",   CMD_READ_AT,   17'h10042, 8'h00, 1'b0);
        add_entry("rn_hi_a16",   CMD_READ_NEXT, 17'h00000, 8'h00, 1'b0);
        add_entry("abort_wr",    CMD_WRITE_AT,  17'h10043, 8'hee, 1'b1);
        add_entry("rd_aborted",  CMD_READ_AT,   17'h10043, 8'h00, 1'b0);
        cycle_limit = n_entries * CYCLES_PER_ENTRY;

        repeat (5) @(negedge sys_clk);
        reset = 1'b0;
        @(negedge sys_clk);
        check_level("reset done_out", 1'b0, done_out);
        check_level("reset spi_miso", 1'b0, spi_miso);
        $display("test after_reset %s", (error_count == 0) ? "ok" : "mismatch");

        for (int k = 0; k < n_entries; k++) begin
            run_entry(k);
        end

        $display("%0d tests, %0d checks, %0d errors", n_entries + 1, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* logic/pi_bridge_top.sv */
`timescale 1ns/1ps

`include "pi_bus_consts.svh"

module pi_bridge_top (
    input  logic sys_clk,
    input  logic reset,
    input  logic spi_sclk,
    input  logic spi_mosi,
    input  logic pending_in,
    output logic spi_miso,
    output logic done_out
);

    import pi_bus_pkg::*;

    logic [`PI_DATA_W-1:0] rx_byte;
    logic                  rx_valid;
    logic                  spi_cs_n;
    pi_bus_req_t           bus_req;
    logic                  bus_pending;
    logic                  bus_done;
    logic [`PI_DATA_W-1:0] rd_data;

    // pending_in doubles as the slave select.
    assign spi_cs_n = !pending_in;

    spi_byte u_spi_byte (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .spi_sclk (spi_sclk),
        .spi_cs_n (spi_cs_n),
        .spi_rx   (spi_mosi),
        .tx_byte  (rd_data),
        .spi_tx   (spi_miso),
        .rx_byte  (rx_byte),
        .valid    (rx_valid)
    );

    pi_com u_pi_com (
        .sys_clk     (sys_clk),
        .reset       (reset),
        .pending_in  (pending_in),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .done_in     (bus_done),
        .req         (bus_req),
        .pending_out (bus_pending),
        .done_out    (done_out)
    );

    bus_ram u_bus_ram (
        .sys_clk (sys_clk),
        .reset   (reset),
        .req     (bus_req),
        .pending (bus_pending),
        .done    (bus_done),
        .rd_data (rd_data)
    );

endmodule

/* logic/bus_ram.sv */
`timescale 1ns/1ps

`include "pi_bus_consts.svh"

module bus_ram (
    input  logic                    sys_clk,
    input  logic                    reset,
    input  pi_bus_pkg::pi_bus_req_t req,
    input  logic                    pending,
    output logic                    done,
    output logic [`PI_DATA_W-1:0]   rd_data
);

    localparam int IDX_W = `PI_RAM_LO_BITS + 1;
    localparam int DEPTH = 1 << IDX_W;

    logic [`PI_DATA_W-1:0] mem [DEPTH];
    logic [IDX_W-1:0]      idx;
    logic                  pending_q;
    logic                  access_q;
    logic                  done_q;
    logic                  start;

    // a16 plus the low bits, the middle address bits alias.
    assign idx   = {req.addr[`PI_ADDR_W-1], req.addr[`PI_RAM_LO_BITS-1:0]};
    assign start = pending && !pending_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // access sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            pending_q <= 1'b0;
            access_q  <= 1'b0;
            done_q    <= 1'b0;
            rd_data   <= '0;
        end else begin
            pending_q <= pending;
            access_q  <= start;
            // done holds until the request goes away.
            done_q    <= pending && (access_q || done_q);
            if (start && req.rw_b) begin
                rd_data <= mem[idx];
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (start && !req.rw_b) begin
            mem[idx] <= req.wr_data;
        end
    end

    // drop done together with pending.
    assign done = done_q && pending;

    // the request must hold still while an access is outstanding.
    assert property (@(posedge sys_clk) disable iff (reset)
        pending && $past(pending) |-> $stable(req));

endmodule

/* logic/pi_com.sv */
`timescale 1ns/1ps

`include "pi_bus_consts.svh"

module pi_com (
    input  logic                    sys_clk,
    input  logic                    reset,
    input  logic                    pending_in,
    input  logic [`PI_DATA_W-1:0]   rx_byte,
    input  logic                    rx_valid,
    input  logic                    done_in,
    output pi_bus_pkg::pi_bus_req_t req,
    output logic                    pending_out,
    output logic                    done_out
);

    import pi_bus_pkg::*;

    pi_com_state_e state;
    pi_cmd_len_e   cmd_len;
    logic          cmd_a16;

    // command byte fields.
    assign cmd_len = pi_cmd_len_e'(rx_byte[`PI_CMD_LEN_HI:`PI_CMD_LEN_LO]);
    assign cmd_a16 = rx_byte[`PI_CMD_A16_BIT];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command decoder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            state       <= ST_READ_CMD;
            pending_out <= 1'b0;
            done_out    <= 1'b0;
            req         <= '{addr: '0, wr_data: '0, rw_b: 1'b1};
        end else if (!pending_in) begin
            // host deselected us, abandon whatever was in flight.
            // the address is kept for a later read-next.
            state       <= ST_READ_CMD;
            pending_out <= 1'b0;
            done_out    <= 1'b0;
        end else begin
            case (state)
                ST_READ_CMD: begin
                    pending_out <= 1'b0;
                    done_out    <= 1'b0;
                    req.rw_b    <= 1'b1;

                    if (rx_valid) begin
                        case (cmd_len)
                            CMD_READ_NEXT: begin
                                req.addr <= req.addr + `PI_ADDR_W'(1);
                                state    <= ST_XFER;
                            end
                            CMD_READ_AT: begin
                                req.addr[`PI_ADDR_W-1] <= cmd_a16;
                                state                  <= ST_READ_ADDR_HI;
                            end
                            default: begin
                                req.addr[`PI_ADDR_W-1] <= cmd_a16;
                                state                  <= ST_READ_DATA;
                            end
                        endcase
                    end
                end

                // write data comes before the address.
                ST_READ_DATA: begin
                    req.rw_b <= 1'b0;

                    if (rx_valid) begin
                        req.wr_data <= rx_byte;
                        state       <= ST_READ_ADDR_HI;
                    end
                end

                ST_READ_ADDR_HI: begin
                    if (rx_valid) begin
                        req.addr[15:8] <= rx_byte;
                        state          <= ST_READ_ADDR_LO;
                    end
                end

                ST_READ_ADDR_LO: begin
                    if (rx_valid) begin
                        req.addr[7:0] <= rx_byte;
                        state         <= ST_XFER;
                    end
                end

                // hold the request until the memory answers.
                ST_XFER: begin
                    pending_out <= 1'b1;

                    if (done_in) begin
                        state <= ST_DONE;
                    end
                end

                // stay here until the host drops pending_in.
                ST_DONE: begin
                    pending_out <= 1'b0;
                    done_out    <= 1'b1;
                end

                default: begin
                    state <= ST_READ_CMD;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the host only sees done once the memory side has been released.
    assert property (@(posedge sys_clk) disable iff (reset)
        !(pending_out && done_out));

    assert property (@(posedge sys_clk) disable iff (reset)
        pending_out |-> state inside {ST_XFER, ST_DONE});

endmodule

/* spi/spi_byte.sv */
`timescale 1ns/1ps

`include "pi_bus_consts.svh"

module spi_byte (
    input  logic                  sys_clk,
    input  logic                  reset,
    input  logic                  spi_sclk,
    input  logic                  spi_cs_n,
    input  logic                  spi_rx,
    input  logic [`PI_DATA_W-1:0] tx_byte,
    output logic                  spi_tx,
    output logic [`PI_DATA_W-1:0] rx_byte,
    output logic                  valid
);

    logic [1:0]            sclk_sync;
    logic [1:0]            mosi_sync;
    logic                  sclk_prev;
    logic                  sclk_rise;
    logic                  sclk_fall;
    logic                  tx_load;
    logic [2:0]            bit_cnt;
    logic [`PI_DATA_W-1:0] rx_shift;
    logic [`PI_DATA_W-1:0] tx_shift;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // serial clock edge detection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // mosi goes through the same two stages so it lines up with sclk.
    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            sclk_sync <= 2'b00;
            mosi_sync <= 2'b00;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_sclk};
            mosi_sync <= {mosi_sync[0], spi_rx};
            sclk_prev <= sclk_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] && !sclk_prev;
    assign sclk_fall = !sclk_sync[1] && sclk_prev;

    // between bytes the shifter follows tx_byte, so read data that
    // arrives late still reaches the first bit.
    assign tx_load = (bit_cnt == 3'd0) && !sclk_sync[1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shift registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            bit_cnt  <= 3'd0;
            valid    <= 1'b0;
            tx_shift <= '0;
        end else if (spi_cs_n) begin
            bit_cnt  <= 3'd0;
            valid    <= 1'b0;
            tx_shift <= tx_byte;
        end else begin
            valid <= sclk_rise && (bit_cnt == 3'd7);
            if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
            end
            if (tx_load) begin
                tx_shift <= tx_byte;
            end else if (sclk_fall) begin
                tx_shift <= {tx_shift[`PI_DATA_W-2:0], 1'b0};
            end
        end
    end

    // msb first on mosi.
    always_ff @(posedge sys_clk) begin
        if (sclk_rise && !spi_cs_n) begin
            rx_shift <= {rx_shift[`PI_DATA_W-2:0], mosi_sync[1]};
        end
    end

    assign rx_byte = rx_shift;
    assign spi_tx  = tx_shift[`PI_DATA_W-1];

    // one pulse per byte, even at the fastest sclk.
    assert property (@(posedge sys_clk) disable iff (reset) valid |=> !valid);

endmodule

/* common/pi_bus_pkg.sv */
`include "pi_bus_consts.svh"

package pi_bus_pkg;

    // one memory bus request, held stable while pending is high.
    typedef struct packed {
        logic [`PI_ADDR_W-1:0] addr;
        logic [`PI_DATA_W-1:0] wr_data;
        logic                  rw_b;
    } pi_bus_req_t;

    // command length field of the command byte.
    // any other length is handled like a write.
    typedef enum logic [2:0] {
        CMD_READ_NEXT = 3'd1,
        CMD_READ_AT   = 3'd3,
        CMD_WRITE_AT  = 3'd4
    } pi_cmd_len_e;

    // command decoder states.
    typedef enum logic [2:0] {
        ST_READ_CMD,
        ST_READ_DATA,
        ST_READ_ADDR_HI,
        ST_READ_ADDR_LO,
        ST_XFER,
        ST_DONE
    } pi_com_state_e;

endpackage

/* common/pi_bus_consts.svh */
`ifndef PI_BUS_CONSTS_SVH
`define PI_BUS_CONSTS_SVH

// bus widths.
`define PI_ADDR_W       17
`define PI_DATA_W       8

// low address bits decoded by the on-chip memory.
`define PI_RAM_LO_BITS  9

// command byte layout.
// bit 0 carries a16, bits 7:5 carry the command length.
`define PI_CMD_A16_BIT  0
`define PI_CMD_RW_BIT   1
`define PI_CMD_LEN_HI   7
`define PI_CMD_LEN_LO   5

`endif
